//--- hdl/fill_if.sv
// miss and refill signals shared by lookup, refill engine and data store

`timescale 1ns/1ps

interface fill_if
    import icache_pkg::*;
#(
    parameter int WAYS       = 4,
    parameter int LINE_WORDS = 32
) ();

    localparam int WAY_W  = $clog2(WAYS);
    localparam int WORD_W = $clog2(LINE_WORDS);

    // miss request, one cycle pulse with block start address
    logic              miss;
    addr_t             miss_addr;

    // refill writes into the victim way
    logic              wr_en;
    logic [WAY_W-1:0]  wr_way;
    logic [WORD_W-1:0] wr_word;
    word_t             wr_data;
    logic              tag_wr;
    logic              done;

    modport lookup (output miss, output miss_addr, input tag_wr, input wr_way, input done);

    modport refill (
        input  miss, miss_addr,
        output wr_en, wr_way, wr_word, wr_data, tag_wr, done
    );

    modport ram (input wr_en, input wr_way, input wr_word, input wr_data);

endinterface

//--- hdl/icache_ctrl.sv
// read-only instruction cache, top level
// lookup, refill engine, data store and response stage

`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int WAYS       = 4,
    parameter int LINE_WORDS = 32
) (
    input  logic     clk,
    input  logic     rst,
    // core request
    input  logic     core_req_valid,
    output logic     core_req_ready,
    input  addr_t    core_req_addr,
    // core response
    output logic     core_resp_valid,
    input  logic     core_resp_ready,
    output word_t    core_resp_data,
    // memory request
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output mem_req_t mem_req,
    // memory response, always accepted
    input  logic     mem_resp_valid,
    input  logic     mem_resp_last,
    input  word_t    mem_resp_data
);

    localparam int WORD_W = $clog2(LINE_WORDS);

    logic              rd_en;
    logic [WORD_W-1:0] rd_word;
    logic [WAYS-1:0]   hit_vec;
    logic              hit;
    word_t [WAYS-1:0]  rd_data;
    logic              resp_taken;

    fill_if #(.WAYS(WAYS), .LINE_WORDS(LINE_WORDS)) u_fill ();

    // ##################################################
    // lookup and refill
    // ##################################################

    icache_lookup #(.WAYS(WAYS), .LINE_WORDS(LINE_WORDS)) u_lookup (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_req_addr  (core_req_addr),
        .resp_taken     (resp_taken),
        .rd_en          (rd_en),
        .rd_word        (rd_word),
        .hit_vec        (hit_vec),
        .hit            (hit),
        .fill           (u_fill.lookup)
    );

    icache_refill #(.WAYS(WAYS), .LINE_WORDS(LINE_WORDS)) u_refill (
        .clk            (clk),
        .rst            (rst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_last  (mem_resp_last),
        .mem_resp_data  (mem_resp_data),
        .fill           (u_fill.refill)
    );

    // ##################################################
    // data store and response
    // ##################################################

    icache_data_ram #(.WAYS(WAYS), .LINE_WORDS(LINE_WORDS)) u_data_ram (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_word (rd_word),
        .fill    (u_fill.ram),
        .rd_data (rd_data)
    );

    icache_resp #(.WAYS(WAYS)) u_resp (
        .clk             (clk),
        .rst             (rst),
        .hit             (hit),
        .hit_vec         (hit_vec),
        .rd_data         (rd_data),
        .core_resp_valid (core_resp_valid),
        .core_resp_ready (core_resp_ready),
        .core_resp_data  (core_resp_data),
        .resp_taken      (resp_taken)
    );

endmodule

//--- hdl/icache_data_ram.sv
// instruction data store, WAYS x LINE_WORDS words
// single write port for refill, same word read from every way

`timescale 1ns/1ps

module icache_data_ram
    import icache_pkg::*;
#(
    parameter int WAYS       = 4,
    parameter int LINE_WORDS = 32
) (
    input  logic                          clk,
    input  logic                          rd_en,
    input  logic [$clog2(LINE_WORDS)-1:0] rd_word,
    fill_if.ram                           fill,
    output word_t [WAYS-1:0]              rd_data
);

    // one block per way
    word_t mem [WAYS][LINE_WORDS];

    // refill write, one word per beat
    always_ff @(posedge clk) begin
        if (fill.wr_en) begin
            mem[fill.wr_way][fill.wr_word] <= fill.wr_data;
        end
    end

    // all ways read in parallel, hit select happens later
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_data[w] <= mem[w][rd_word];
            end
        end
    end

endmodule

//--- hdl/icache_lookup.sv
// request decode, tag store and tag compare
// main cache FSM: IDLE, TAG_CMP, REFILL, RESP

`timescale 1ns/1ps

module icache_lookup
    import icache_pkg::*;
#(
    parameter int WAYS       = 4,
    parameter int LINE_WORDS = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          core_req_valid,
    output logic                          core_req_ready,
    input  addr_t                         core_req_addr,
    input  logic                          resp_taken,
    output logic                          rd_en,
    output logic [$clog2(LINE_WORDS)-1:0] rd_word,
    output logic [WAYS-1:0]               hit_vec,
    output logic                          hit,
    fill_if.lookup                        fill
);

    localparam int WORD_W  = $clog2(LINE_WORDS);
    localparam int TAG_W   = ADDR_W - OFFSET_W - WORD_W;
    localparam int TAG_LSB = OFFSET_W + WORD_W;

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        TAG_CMP = 2'b01,
        REFILL  = 2'b10,
        RESP    = 2'b11
    } state_t;

    state_t           state;
    state_t           state_nxt;
    addr_t            req_addr;
    logic [TAG_W-1:0] req_tag;
    logic [WAYS-1:0]  tag_valid;
    logic [TAG_W-1:0] tag_q [WAYS];
    logic             any_hit;
    logic             accept;

    // ##################################################
    // address decode
    // ##################################################

    assign core_req_ready = (state == IDLE);
    assign accept         = core_req_valid & core_req_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= core_req_addr;
        end
    end

    assign req_tag = req_addr[ADDR_W-1:TAG_LSB];

    // data store read, first pass and retry both go through TAG_CMP
    assign rd_en   = (state == TAG_CMP);
    assign rd_word = req_addr[TAG_LSB-1:OFFSET_W];

    // ##################################################
    // tag store and compare
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_valid <= '0;
        end else if (fill.tag_wr) begin
            tag_valid[fill.wr_way] <= 1'b1;
        end
    end

    // tag of the block being refilled is still in req_addr
    always_ff @(posedge clk) begin
        if (fill.tag_wr) begin
            tag_q[fill.wr_way] <= req_tag;
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = tag_valid[w] && (tag_q[w] == req_tag);
        end
    end

    assign any_hit = |hit_vec;

    // miss goes out with the block start address
    assign fill.miss      = (state == TAG_CMP) & ~any_hit;
    assign fill.miss_addr = {req_tag, {(ADDR_W - TAG_W){1'b0}}};

    // ##################################################
    // state machine
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            hit   <= 1'b0;
        end else begin
            state <= state_nxt;
            // one cycle strobe, lines up with the read data
            hit   <= (state == TAG_CMP) & any_hit;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = TAG_CMP;
                end
            end
            TAG_CMP: begin
                state_nxt = any_hit ? RESP : REFILL;
            end
            REFILL: begin
                if (fill.done) begin
                    state_nxt = TAG_CMP;
                end
            end
            RESP: begin
                if (resp_taken) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // refill never installs a block that is already resident
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

//--- hdl/icache_pkg.sv
// shared widths for the instruction cache
// byte address and instruction word types
// memory read burst request

package icache_pkg;

    // ##################################################
    // widths
    // ##################################################

    // byte address
    localparam int ADDR_W   = 32;
    // one instruction word
    localparam int DATA_W   = 32;
    // byte offset inside a word
    localparam int OFFSET_W = $clog2(DATA_W / 8);

    // burst length field, in words
    localparam int BURST_W  = 16;

    // ##################################################
    // types
    // ##################################################

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] word_t;

    // read burst, always block aligned
    typedef struct packed {
        addr_t              addr;
        logic [BURST_W-1:0] burst_len;
    } mem_req_t;

endpackage

//--- hdl/icache_refill.sv
// refill engine FSM: FILL_IDLE, FETCH_REQ, FETCH_RESP, TAG_WRITE
// memory burst request, word pointer and round robin victim pointer

`timescale 1ns/1ps

module icache_refill
    import icache_pkg::*;
#(
    parameter int WAYS       = 4,
    parameter int LINE_WORDS = 32
) (
    input  logic     clk,
    input  logic     rst,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output mem_req_t mem_req,
    input  logic     mem_resp_valid,
    input  logic     mem_resp_last,
    input  word_t    mem_resp_data,
    fill_if.refill   fill
);

    localparam int WAY_W  = $clog2(WAYS);
    localparam int WORD_W = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {
        FILL_IDLE  = 2'b00,
        FETCH_REQ  = 2'b01,
        FETCH_RESP = 2'b10,
        TAG_WRITE  = 2'b11
    } fill_state_t;

    fill_state_t       state;
    fill_state_t       state_nxt;
    addr_t             base_addr;
    logic [WORD_W-1:0] word_ptr;
    logic [WAY_W-1:0]  victim;
    logic              beat;
    logic              done_q;

    // ##################################################
    // memory request
    // ##################################################

    // block start, only loaded while idle
    always_ff @(posedge clk) begin
        if (fill.miss && state == FILL_IDLE) begin
            base_addr <= fill.miss_addr;
        end
    end

    assign mem_req_valid     = (state == FETCH_REQ);
    assign mem_req.addr      = base_addr;
    assign mem_req.burst_len = BURST_W'(LINE_WORDS);

    // ##################################################
    // beat write and pointers
    // ##################################################

    assign beat = (state == FETCH_RESP) & mem_resp_valid;

    assign fill.wr_en   = beat;
    assign fill.wr_way  = victim;
    assign fill.wr_word = word_ptr;
    assign fill.wr_data = mem_resp_data;
    assign fill.tag_wr  = (state == TAG_WRITE);
    assign fill.done    = done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            word_ptr <= '0;
            victim   <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= fill.tag_wr;
            if (fill.miss) begin
                word_ptr <= '0;
            end else if (beat) begin
                word_ptr <= word_ptr + 1'b1;
            end
            // next victim once the tag is in place
            if (fill.tag_wr) begin
                victim <= (victim == WAY_W'(WAYS - 1)) ? '0 : victim + 1'b1;
            end
        end
    end

    // ##################################################
    // state machine
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            FILL_IDLE: begin
                if (fill.miss) begin
                    state_nxt = FETCH_REQ;
                end
            end
            FETCH_REQ: begin
                if (mem_req_ready) begin
                    state_nxt = FETCH_RESP;
                end
            end
            FETCH_RESP: begin
                if (beat && mem_resp_last) begin
                    state_nxt = TAG_WRITE;
                end
            end
            default: begin
                state_nxt = FILL_IDLE;
            end
        endcase
    end

    // request and its payload hold until memory takes it
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

//--- hdl/icache_resp.sv
// hit way select and core response register
// holds valid and data under back-pressure

`timescale 1ns/1ps

module icache_resp
    import icache_pkg::*;
#(
    parameter int WAYS = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             hit,
    input  logic [WAYS-1:0]  hit_vec,
    input  word_t [WAYS-1:0] rd_data,
    output logic             core_resp_valid,
    input  logic             core_resp_ready,
    output word_t            core_resp_data,
    output logic             resp_taken
);

    word_t hit_word;

    // and-or mux, hit_vec is one-hot on a hit
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_word = hit_word | (rd_data[w] & {DATA_W{hit_vec[w]}});
        end
    end

    assign resp_taken = core_resp_valid & core_resp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            core_resp_valid <= 1'b0;
        end else if (hit) begin
            core_resp_valid <= 1'b1;
        end else if (resp_taken) begin
            core_resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            core_resp_data <= hit_word;
        end
    end

    // stalled response keeps its word
    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        core_resp_valid && !core_resp_ready |=> core_resp_valid && $stable(core_resp_data));

endmodule

//--- run.sh
#!/bin/sh
# build the instruction cache testbench with Verilator and run it
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_icache_ctrl \
    && ./obj_dir/Vtb_icache_ctrl > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^test passed$" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

//--- tb/icache_model.svh
// reference model for the instruction cache testbench
// memory contents rule, resident blocks per way, round robin victim
// compare tasks for words, memory requests, flags and cycle counts

addr_t model_block [WAYS];
logic  model_valid [WAYS];
int    model_victim;

// memory word for any byte address, taken at the word boundary
function automatic word_t mem_word(addr_t a);
    addr_t aligned;
    aligned = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    return aligned ^ 32'hA5A5_5A5A;
endfunction

function automatic addr_t block_of(addr_t a);
    return a & ~addr_t'(LINE_WORDS * 4 - 1);
endfunction

// way holding the block, or -1 when absent
function automatic int model_find(addr_t a);
    int found;
    found = -1;
    for (int w = 0; w < WAYS; w++) begin
        if (model_valid[w] && model_block[w] == block_of(a)) begin
            found = w;
        end
    end
    return found;
endfunction

task automatic model_clear();
    for (int w = 0; w < WAYS; w++) begin
        model_valid[w] = 1'b0;
        model_block[w] = '0;
    end
    model_victim = 0;
endtask

// refill goes to the victim, pointer moves on afterwards
task automatic model_install(addr_t a);
    model_block[model_victim] = block_of(a);
    model_valid[model_victim] = 1'b1;
    model_victim = (model_victim + 1) % WAYS;
endtask

// ##################################################
// compare tasks
// ##################################################

task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
        $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_req(mem_req_t got, mem_req_t exp);
    if (got !== exp) begin
        $display("FAIL at %0t: mem_req got addr %h len %0d expected addr %h len %0d",
                 $time, got.addr, got.burst_len, exp.addr, exp.burst_len);
        stop_on_error();
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_cycles(string name, int got, int exp);
    if (got != exp) begin
        $display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp);
        stop_on_error();
    end
endtask

//--- tb/tb_icache_ctrl.sv
// testbench for the instruction cache controller
// clock, reset, random accesses over six blocks, memory responder, checks

`timescale 1ns/1ps

module tb_icache_ctrl
    import icache_pkg::*;
;

    localparam int WAYS       = 4;
    localparam int LINE_WORDS = 32;
    localparam int BLK_LSB    = $clog2(LINE_WORDS * 4);
    localparam int NUM_BLOCKS = 6;
    localparam int TIMEOUT    = 500;

    logic     clk;
    logic     rst;
    logic     core_req_valid;
    logic     core_req_ready;
    addr_t    core_req_addr;
    logic     core_resp_valid;
    logic     core_resp_ready;
    word_t    core_resp_data;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_req_t mem_req;
    logic     mem_resp_valid;
    logic     mem_resp_last;
    word_t    mem_resp_data;

    addr_t    block_base [NUM_BLOCKS];

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic wait_timeout(string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        stop_on_error();
    endtask

    `include "icache_model.svh"

    icache_ctrl #(.WAYS(WAYS), .LINE_WORDS(LINE_WORDS)) u_icache_ctrl (
        .clk             (clk),
        .rst             (rst),
        .core_req_valid  (core_req_valid),
        .core_req_ready  (core_req_ready),
        .core_req_addr   (core_req_addr),
        .core_resp_valid (core_resp_valid),
        .core_resp_ready (core_resp_ready),
        .core_resp_data  (core_resp_data),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req         (mem_req),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_last   (mem_resp_last),
        .mem_resp_data   (mem_resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ##################################################
    // memory responder
    // ##################################################

    // beats in address order, random gaps between them
    task automatic send_burst(addr_t base);
        int gap;
        for (int i = 0; i < LINE_WORDS; i++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                mem_resp_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            mem_resp_valid = 1'b1;
            mem_resp_data  = mem_word(base + addr_t'(i * 4));
            mem_resp_last  = (i == LINE_WORDS - 1);
            @(posedge clk);
            #1;
        end
        mem_resp_valid = 1'b0;
        mem_resp_last  = 1'b0;
    endtask

    task automatic serve_miss(addr_t a);
        mem_req_t exp_req;
        int       cycles;
        int       delay;
        exp_req.addr      = block_of(a);
        exp_req.burst_len = BURST_W'(LINE_WORDS);
        cycles = 0;
        while (!mem_req_valid) begin
            check_flag("core_resp_valid", core_resp_valid, 1'b0);
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                wait_timeout("mem_req_valid on a miss");
            end
        end
        check_req(mem_req, exp_req);
        delay = $urandom % 4;
        repeat (delay) begin
            @(posedge clk);
            #1;
            check_flag("mem_req_valid", mem_req_valid, 1'b1);
        end
        mem_req_ready = 1'b1;
        @(posedge clk);
        #1;
        mem_req_ready = 1'b0;
        send_burst(exp_req.addr);
        model_install(a);
    endtask

    // ##################################################
    // core side
    // ##################################################

    task automatic run_access(addr_t a);
        int    way;
        int    cycles;
        int    stall;
        way = model_find(a);
        core_req_valid = 1'b1;
        core_req_addr  = a;
        cycles = 0;
        while (!core_req_ready) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                wait_timeout("core_req_ready");
            end
        end
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
        if (way < 0) begin
            serve_miss(a);
        end
        // no request to memory while the answer is pending
        cycles = 0;
        while (!core_resp_valid) begin
            check_flag("mem_req_valid", mem_req_valid, 1'b0);
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                wait_timeout("core_resp_valid");
            end
        end
        if (way >= 0) begin
            check_cycles("hit latency", cycles, 2);
        end
        check_word("core_resp_data", core_resp_data, mem_word(a));
        stall = ($urandom % 2) ? 0 : int'($urandom % 5);
        repeat (stall) begin
            @(posedge clk);
            #1;
            check_flag("core_resp_valid", core_resp_valid, 1'b1);
            check_word("core_resp_data", core_resp_data, mem_word(a));
            check_flag("core_req_ready", core_req_ready, 1'b0);
        end
        core_resp_ready = 1'b1;
        @(posedge clk);
        #1;
        core_resp_ready = 1'b0;
        check_flag("core_req_ready", core_req_ready, 1'b1);
        check_flag("core_resp_valid", core_resp_valid, 1'b0);
    endtask

    function automatic addr_t pick_addr(int blk);
        return block_base[blk] + addr_t'(($urandom % LINE_WORDS) * 4) + addr_t'($urandom % 4);
    endfunction

    // ##################################################
    // main sequence
    // ##################################################

    initial begin
        addr_t tmp;
        void'($urandom(32'h7913));
        rst             = 1'b1;
        core_req_valid  = 1'b0;
        core_req_addr   = '0;
        core_resp_ready = 1'b0;
        mem_req_ready   = 1'b0;
        mem_resp_valid  = 1'b0;
        mem_resp_last   = 1'b0;
        mem_resp_data   = '0;
        model_clear();
        // distinct blocks, index sits just above the block offset
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            tmp           = $urandom;
            block_base[i] = ((tmp >> 10) << 10) | addr_t'(i << BLK_LSB);
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("core_resp_valid", core_resp_valid, 1'b0);
        check_flag("mem_req_valid", mem_req_valid, 1'b0);
        check_flag("core_req_ready", core_req_ready, 1'b1);

        // five distinct blocks, then the first one again after eviction
        for (int b = 0; b <= WAYS; b++) begin
            run_access(pick_addr(b));
        end
        run_access(pick_addr(0));
        for (int b = 2; b <= WAYS; b++) begin
            run_access(pick_addr(b));
        end

        for (int n = 0; n < 200; n++) begin
            run_access(pick_addr(int'($urandom % NUM_BLOCKS)));
        end

        $display("test passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tb
hdl/icache_pkg.sv
hdl/fill_if.sv
hdl/icache_lookup.sv
hdl/icache_refill.sv
hdl/icache_data_ram.sv
hdl/icache_resp.sv
hdl/icache_ctrl.sv
tb/tb_icache_ctrl.sv
